/* build.f */
+incdir+include
rtl/mem_pkg.sv
rtl/mem_req_decode.sv
rtl/data_mem.sv
rtl/load_align.sv
rtl/mem_forward.sv
rtl/mem_top.sv
tests/mem_top_tb.sv

/* Makefile */
# Verilator build and run for the memory stage testbench.
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mem_top_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/mem_top_tb.sv */
// Memory stage testbench.
// Runs directed and LFSR-driven instructions through the memory stage, keeps
// a byte-array model of the data memory and a queue of expected write-back
// items, and checks write-back, handshake and forwarding with assertions.

`include "mem_params.svh"

module mem_top_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int ABITS = `MEM_WORDS_BITS + 2; // Byte address bits the memory decodes.

    logic                 clk, arst_n;
    logic                 ex_valid, ex_ready, ex_write_gpr, ex_mem_read, ex_mem_write;
    logic                 ex_mem_unsigned;
    logic [`XLEN-1:0]     ex_pc, ex_alu_out, ex_rs2_data;
    logic [`REG_BITS-1:0] ex_rd;
    logic [1:0]           ex_mem_size;
    logic                 wb_valid, wb_ready, wb_write_gpr;
    logic [`XLEN-1:0]     wb_pc, wb_data;
    logic [`REG_BITS-1:0] wb_rd, id_rs1, id_rs2;
    logic                 fwd_rs1_hit, fwd_rs2_hit, load_use_stall;
    logic [`XLEN-1:0]     fwd_rs1_data, fwd_rs2_data;

    logic [7:0]           ref_mem [4*`MEM_WORDS];
    logic [`XLEN-1:0]     q_pc [$];
    logic [`XLEN-1:0]     q_data [$];
    logic [`REG_BITS-1:0] q_rd [$];
    logic                 q_wgpr [$];
    logic                 q_load [$];
    logic                 exp_m_valid, exp_m_wgpr, exp_m_load, exp_w_valid, exp_w_wgpr;
    logic [`REG_BITS-1:0] exp_m_rd, exp_w_rd;
    logic [`XLEN-1:0]     exp_m_data, exp_w_pc, exp_w_data, pc_d1, pc_next;
    logic                 exp_ready, acc_d1, hold_wb, rand_ready;
    logic [33:0]          fwd1_ref, fwd2_ref;
    logic [31:0]          lfsr_state;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] load_ref(input logic [31:0] addr, input logic [1:0] size,
                                             input logic uns);
        logic [ABITS-1:0] a;
        logic [15:0]      h;
        logic [31:0]      w;
        a = addr[ABITS-1:0];
        h = {ref_mem[{a[ABITS-1:1], 1'b1}], ref_mem[{a[ABITS-1:1], 1'b0}]};
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = ref_mem[{a[ABITS-1:2], 2'(i)}];
        end
        if (size == `MEM_SZ_BYTE) begin
            return uns ? {24'd0, ref_mem[a]} : {{24{ref_mem[a][7]}}, ref_mem[a]};
        end else if (size == `MEM_SZ_HALF) begin
            return uns ? {16'd0, h} : {{16{h[15]}}, h};
        end
        return w;
    endfunction

    task automatic store_ref(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] size);
        logic [ABITS-1:0] a;
        a = addr[ABITS-1:0];
        if (size == `MEM_SZ_BYTE) begin
            ref_mem[a] = data[7:0];
        end else if (size == `MEM_SZ_HALF) begin
            ref_mem[{a[ABITS-1:1], 1'b0}] = data[7:0];
            ref_mem[{a[ABITS-1:1], 1'b1}] = data[15:8];
        end else begin
            for (int i = 0; i < 4; i++) begin
                ref_mem[{a[ABITS-1:2], 2'(i)}] = data[8*i +: 8];
            end
        end
    endtask

    // Returns {stall, hit, data}; a load in m stalls, then m beats w.
    function automatic logic [33:0] forward_ref(input logic [`REG_BITS-1:0] rs);
        logic m_match;
        logic w_match;
        m_match = exp_m_valid && exp_m_wgpr && (exp_m_rd == rs) && (rs != '0);
        w_match = exp_w_valid && exp_w_wgpr && (exp_w_rd == rs) && (rs != '0);
        if (m_match && exp_m_load) begin
            return {2'b10, 32'd0};
        end else if (m_match) begin
            return {2'b01, exp_m_data};
        end else if (w_match) begin
            return {2'b01, exp_w_data};
        end
        return '0;
    endfunction

    always_comb begin
        fwd1_ref = forward_ref(id_rs1);
        fwd2_ref = forward_ref(id_rs2);
    end

    assign exp_ready = !exp_m_valid || !exp_w_valid || wb_ready;

    // Reference pipeline. The queue holds the items in m and w, oldest first.
    always @(posedge clk) begin
        logic w_adv;
        logic take;
        logic new_w;
        logic new_m;
        int   mi;
        if (!arst_n) begin
            q_pc.delete();
            q_data.delete();
            q_rd.delete();
            q_wgpr.delete();
            q_load.delete();
            exp_m_valid <= 1'b0;
            exp_w_valid <= 1'b0;
            acc_d1      <= 1'b0;
        end else begin
            w_adv = !exp_w_valid || wb_ready;
            take  = ex_valid && (!exp_m_valid || w_adv);
            if (exp_w_valid && wb_ready) begin
                void'(q_pc.pop_front());
                void'(q_data.pop_front());
                void'(q_rd.pop_front());
                void'(q_wgpr.pop_front());
                void'(q_load.pop_front());
            end
            if (take) begin
                q_pc.push_back(ex_pc);
                q_data.push_back(ex_mem_read ? load_ref(ex_alu_out, ex_mem_size, ex_mem_unsigned)
                                             : ex_alu_out);
                q_rd.push_back(ex_rd);
                q_wgpr.push_back(ex_write_gpr);
                q_load.push_back(ex_mem_read);
                if (ex_mem_write) begin
                    store_ref(ex_alu_out, ex_rs2_data, ex_mem_size);
                end
            end
            new_w = w_adv ? exp_m_valid : exp_w_valid;
            new_m = take || (exp_m_valid && !w_adv);
            mi    = new_w ? 1 : 0;
            exp_w_valid <= new_w;
            exp_m_valid <= new_m;
            if (new_w) begin
                exp_w_pc   <= q_pc[0];
                exp_w_rd   <= q_rd[0];
                exp_w_wgpr <= q_wgpr[0];
                exp_w_data <= q_data[0];
            end
            if (new_m) begin
                exp_m_rd   <= q_rd[mi];
                exp_m_wgpr <= q_wgpr[mi];
                exp_m_load <= q_load[mi];
                exp_m_data <= q_data[mi];
            end
            acc_d1 <= take;
            pc_d1  <= ex_pc;
        end
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    reset_state: assert property (@(posedge clk) $rose(arst_n) |->
        (ex_ready && !wb_valid && !load_use_stall && !fwd_rs1_hit && !fwd_rs2_hit))
        else report_fail("outputs after reset are not idle");
    ready_match: assert property (@(posedge clk) disable iff (!arst_n) ex_ready == exp_ready)
        else report_fail("ex_ready differs from the model");
    valid_match: assert property (@(posedge clk) disable iff (!arst_n) wb_valid == exp_w_valid)
        else report_fail("wb_valid differs from the model");
    item_match: assert property (@(posedge clk) disable iff (!arst_n) wb_valid |->
        (wb_pc == exp_w_pc && wb_rd == exp_w_rd && wb_write_gpr == exp_w_wgpr &&
         wb_data == exp_w_data))
        else report_fail($sformatf("write-back pc %h data %h, expected pc %h data %h",
                                   wb_pc, wb_data, exp_w_pc, exp_w_data));
    hold_stable: assert property (@(posedge clk) disable iff (!arst_n) (wb_valid && !wb_ready)
        |=> (wb_valid && $stable(wb_pc) && $stable(wb_rd) && $stable(wb_write_gpr) &&
             $stable(wb_data)))
        else report_fail("write-back fields changed under back-pressure");
    one_edge: assert property (@(posedge clk) disable iff (!arst_n)
        (acc_d1 && (!wb_valid || wb_ready)) |=> (wb_valid && wb_pc == $past(pc_d1)))
        else report_fail("accepted instruction did not reach write-back one edge later");
    fwd_rs1: assert property (@(posedge clk) disable iff (!arst_n)
        (fwd_rs1_hit == fwd1_ref[32] && fwd_rs1_data == fwd1_ref[31:0]))
        else report_fail($sformatf("rs1 %0d hit %b data %h", id_rs1, fwd_rs1_hit, fwd_rs1_data));
    fwd_rs2: assert property (@(posedge clk) disable iff (!arst_n)
        (fwd_rs2_hit == fwd2_ref[32] && fwd_rs2_data == fwd2_ref[31:0]))
        else report_fail($sformatf("rs2 %0d hit %b data %h", id_rs2, fwd_rs2_hit, fwd_rs2_data));
    stall_match: assert property (@(posedge clk) disable iff (!arst_n)
        load_use_stall == (fwd1_ref[33] || fwd2_ref[33]))
        else report_fail($sformatf("load_use_stall is %b", load_use_stall));

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s did not happen in time at %0t ns", what, $time);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic issue(input logic [31:0] alu, input logic [31:0] rs2,
                         input logic [`REG_BITS-1:0] rd, input logic wgpr, input logic rd_en,
                         input logic wr_en, input logic [1:0] size, input logic uns);
        int   waited;
        logic taken;
        ex_pc           = pc_next;
        ex_alu_out      = alu;
        ex_rs2_data     = rs2;
        ex_rd           = rd;
        ex_write_gpr    = wgpr;
        ex_mem_read     = rd_en;
        ex_mem_write    = wr_en;
        ex_mem_size     = size;
        ex_mem_unsigned = uns;
        ex_valid        = 1'b1;
        pc_next         = pc_next + 32'd4;
        waited          = 0;
        taken           = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = ex_ready;
            @(negedge clk);
            waited++;
            if (!taken && waited > 100) begin
                abort_on_timeout("acceptance by ex_ready");
            end
        end
        ex_valid = 1'b0;
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data, input logic [1:0] size);
        issue(addr, data, '0, 1'b0, 1'b0, 1'b1, size, 1'b0);
    endtask

    task automatic load(input logic [31:0] addr, input logic [`REG_BITS-1:0] rd,
                        input logic [1:0] size, input logic uns);
        issue(addr, 32'hdead_beef, rd, 1'b1, 1'b1, 1'b0, size, uns);
    endtask

    task automatic alu_op(input logic [31:0] value, input logic [`REG_BITS-1:0] rd);
        issue(value, '0, rd, 1'b1, 1'b0, 1'b0, `MEM_SZ_WORD, 1'b0);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_m_valid || exp_w_valid || wb_valid) begin
            @(negedge clk);
            waited++;
            if (waited > 200) begin
                abort_on_timeout("draining the stage");
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, name, errors == errs_before ? "pass" : "failed");
    endtask

    function automatic logic [31:0] word_addr(input logic [7:0] idx);
        return 32'h0001_0000 | {22'd0, idx, 2'b00};
    endfunction

    // The next wb_ready is chosen on the rising edge and driven on the falling one.
    initial begin
        logic next_ready;
        wb_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (hold_wb) begin
                next_ready = 1'b0;
            end else if (rand_ready) begin
                next_ready = (rand_bits(2) != 32'd0); // Ready three cycles in four.
            end else begin
                next_ready = 1'b1;
            end
            @(negedge clk);
            wb_ready = next_ready;
        end
    end

    initial begin
        int          errs;
        logic [31:0] base;
        logic [1:0]  kind;
        logic [1:0]  size;
        lfsr_state      = 32'h123d0c07;
        pc_next         = 32'h0000_1000;
        hold_wb         = 1'b0;
        rand_ready      = 1'b0;
        arst_n          = 1'b0;
        ex_valid        = 1'b0;
        ex_pc           = '0;
        ex_alu_out      = '0;
        ex_rs2_data     = '0;
        ex_rd           = '0;
        ex_write_gpr    = 1'b0;
        ex_mem_read     = 1'b0;
        ex_mem_write    = 1'b0;
        ex_mem_size     = `MEM_SZ_WORD;
        ex_mem_unsigned = 1'b0;
        id_rs1          = '0;
        id_rs2          = '0;
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
        end
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        end_test("reset state", 0);

        errs = errors;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            store(word_addr(8'(i)), {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3 + 8'(i)}, `MEM_SZ_WORD);
        end
        for (int k = 0; k < 8; k++) begin
            base = word_addr(8'(rand_bits(8)));
            store(base, rand_bits(32), `MEM_SZ_WORD);
            store(base + rand_bits(2), rand_bits(32), `MEM_SZ_HALF);
            store(base + rand_bits(2), rand_bits(32), `MEM_SZ_BYTE);
            for (int off = 0; off < 4; off++) begin
                load(base + off, 5'd10, `MEM_SZ_BYTE, 1'b0);
                load(base + off, 5'd10, `MEM_SZ_BYTE, 1'b1);
                load(base + off, 5'd10, `MEM_SZ_HALF, 1'b0);
                load(base + off, 5'd10, `MEM_SZ_HALF, 1'b1);
                load(base + off, 5'd10, `MEM_SZ_WORD, 1'b0);
            end
            alu_op(rand_bits(32), 5'd11);
        end
        drain();
        end_test("stores and aligned loads", errs);

        errs = errors;
        rand_ready = 1'b1;
        for (int n = 0; n < 300; n++) begin
            kind   = 2'(rand_bits(2));
            size   = 2'(rand_bits(2));
            size   = (size == 2'd3) ? `MEM_SZ_WORD : size;
            base   = word_addr(8'(rand_bits(8))) + rand_bits(2);
            id_rs1 = 5'(rand_bits(3));
            id_rs2 = 5'(rand_bits(3));
            if (kind == 2'd0) begin
                store(base, rand_bits(32), size);
            end else if (kind == 2'd3) begin
                alu_op(rand_bits(32), 5'(rand_bits(3)));
            end else begin
                load(base, 5'(rand_bits(3)), size, 1'(rand_bits(1)));
            end
        end
        drain();
        rand_ready = 1'b0;
        end_test("random back-pressure", errs);

        errs   = errors;
        id_rs1 = 5'd5;
        id_rs2 = 5'd6;
        alu_op(32'h1111_0005, 5'd5);
        alu_op(32'h2222_0005, 5'd5); // Both stages hold x5 here.
        alu_op(32'h3333_0006, 5'd6);
        issue(32'h4444_0005, '0, 5'd5, 1'b0, 1'b0, 1'b0, `MEM_SZ_WORD, 1'b0);
        drain();
        id_rs1 = 5'd0;
        id_rs2 = 5'd0;
        alu_op(32'h5555_0000, 5'd0);
        alu_op(32'h6666_0000, 5'd0);
        drain();
        end_test("forwarding priority", errs);

        errs   = errors;
        id_rs1 = 5'd7;
        id_rs2 = 5'd8;
        load(word_addr(8'd3) + 32'd1, 5'd7, `MEM_SZ_BYTE, 1'b0);
        drain();
        hold_wb = 1'b1;
        @(negedge clk);
        alu_op(32'h600d_0001, 5'd1);
        load(word_addr(8'd9) + 32'd2, 5'd8, `MEM_SZ_HALF, 1'b1);
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
        end
        hold_wb = 1'b0;
        drain();
        end_test("load-use stall", errs);

        $display("Tests: %0d run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* rtl/mem_top.sv */
// Memory stage top level.
// Request decode feeds the data memory and stage register m, load alignment
// holds stage register w towards write-back, and the forwarding unit looks
// at both registers for the decode stage.

`include "mem_params.svh"

module mem_top import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 ex_valid,
    output logic                 ex_ready,
    input  logic [`XLEN-1:0]     ex_pc,
    input  logic [`XLEN-1:0]     ex_alu_out,
    input  logic [`XLEN-1:0]     ex_rs2_data,
    input  logic [`REG_BITS-1:0] ex_rd,
    input  logic                 ex_write_gpr,
    input  logic                 ex_mem_read,
    input  logic                 ex_mem_write,
    input  logic [1:0]           ex_mem_size,
    input  logic                 ex_mem_unsigned,

    output logic                 wb_valid,
    input  logic                 wb_ready,
    output logic [`XLEN-1:0]     wb_pc,
    output logic [`REG_BITS-1:0] wb_rd,
    output logic                 wb_write_gpr,
    output logic [`XLEN-1:0]     wb_data,

    input  logic [`REG_BITS-1:0] id_rs1,
    input  logic [`REG_BITS-1:0] id_rs2,
    output logic                 fwd_rs1_hit,
    output logic [`XLEN-1:0]     fwd_rs1_data,
    output logic                 fwd_rs2_hit,
    output logic [`XLEN-1:0]     fwd_rs2_data,
    output logic                 load_use_stall
);

    logic [`MEM_WORDS_BITS-1:0] word_index;
    logic [3:0]                 byte_en;
    mem_word_t                  lane_data;
    logic                       w_advance;
    logic                       m_valid;
    mem_word_t                  m_rdata;
    logic [`XLEN-1:0]           m_pc;
    logic [`XLEN-1:0]           m_alu_out;
    logic [`REG_BITS-1:0]       m_rd;
    logic                       m_write_gpr;
    logic                       m_mem_read;
    logic [1:0]                 m_mem_size;
    logic                       m_mem_unsigned;

    mem_req_decode mem_req_decode_inst (
        .addr           (ex_alu_out     ),
        .mem_size       (ex_mem_size    ),
        .store_data     (ex_rs2_data    ),
        .word_index     (word_index     ),
        .byte_en        (byte_en        ),
        .lane_data      (lane_data      )
    );

    data_mem data_mem_inst (
        .clk            (clk            ),
        .arst_n         (arst_n         ),
        .in_valid       (ex_valid       ),
        .in_ready       (ex_ready       ),
        .word_index     (word_index     ),
        .byte_en        (byte_en        ),
        .lane_data      (lane_data      ),
        .is_write       (ex_mem_write   ),
        .is_read        (ex_mem_read    ),
        .pc             (ex_pc          ),
        .alu_out        (ex_alu_out     ),
        .rd             (ex_rd          ),
        .write_gpr      (ex_write_gpr   ),
        .mem_size       (ex_mem_size    ),
        .mem_unsigned   (ex_mem_unsigned),
        .advance_out    (w_advance      ),
        .m_valid        (m_valid        ),
        .m_rdata        (m_rdata        ),
        .m_pc           (m_pc           ),
        .m_alu_out      (m_alu_out      ),
        .m_rd           (m_rd           ),
        .m_write_gpr    (m_write_gpr    ),
        .m_mem_read     (m_mem_read     ),
        .m_mem_size     (m_mem_size     ),
        .m_mem_unsigned (m_mem_unsigned )
    );

    load_align load_align_inst (
        .clk            (clk            ),
        .arst_n         (arst_n         ),
        .m_valid        (m_valid        ),
        .m_rdata        (m_rdata        ),
        .m_pc           (m_pc           ),
        .m_alu_out      (m_alu_out      ),
        .m_rd           (m_rd           ),
        .m_write_gpr    (m_write_gpr    ),
        .m_mem_read     (m_mem_read     ),
        .m_mem_size     (m_mem_size     ),
        .m_mem_unsigned (m_mem_unsigned ),
        .advance_out    (w_advance      ),
        .wb_valid       (wb_valid       ),
        .wb_ready       (wb_ready       ),
        .wb_pc          (wb_pc          ),
        .wb_rd          (wb_rd          ),
        .wb_write_gpr   (wb_write_gpr   ),
        .wb_data        (wb_data        )
    );

    mem_forward mem_forward_inst (
        .id_rs1         (id_rs1         ),
        .id_rs2         (id_rs2         ),
        .m_valid        (m_valid        ),
        .m_rd           (m_rd           ),
        .m_write_gpr    (m_write_gpr    ),
        .m_mem_read     (m_mem_read     ),
        .m_alu_out      (m_alu_out      ),
        .wb_valid       (wb_valid       ),
        .wb_rd          (wb_rd          ),
        .wb_write_gpr   (wb_write_gpr   ),
        .wb_data        (wb_data        ),
        .fwd_rs1_hit    (fwd_rs1_hit    ),
        .fwd_rs1_data   (fwd_rs1_data   ),
        .fwd_rs2_hit    (fwd_rs2_hit    ),
        .fwd_rs2_data   (fwd_rs2_data   ),
        .load_use_stall (load_use_stall )
    );

endmodule

/* rtl/mem_forward.sv */
// Forwarding and load-use hazard unit.
// Compares the decode stage's two source registers with the destinations
// held in stage registers m and w. The younger m entry wins, and a load
// still waiting in m stalls decode instead of forwarding.

`include "mem_params.svh"

module mem_forward (
    input  logic [`REG_BITS-1:0] id_rs1,
    input  logic [`REG_BITS-1:0] id_rs2,

    input  logic                 m_valid,
    input  logic [`REG_BITS-1:0] m_rd,
    input  logic                 m_write_gpr,
    input  logic                 m_mem_read,
    input  logic [`XLEN-1:0]     m_alu_out,

    input  logic                 wb_valid,
    input  logic [`REG_BITS-1:0] wb_rd,
    input  logic                 wb_write_gpr,
    input  logic [`XLEN-1:0]     wb_data,

    output logic                 fwd_rs1_hit,
    output logic [`XLEN-1:0]     fwd_rs1_data,
    output logic                 fwd_rs2_hit,
    output logic [`XLEN-1:0]     fwd_rs2_data,
    output logic                 load_use_stall
);

    logic [`REG_BITS-1:0] src      [2];
    logic [1:0]           m_match;
    logic [1:0]           w_match;
    logic [1:0]           src_stall;
    logic [1:0]           hit;
    logic [`XLEN-1:0]     data     [2];

    assign src[0] = id_rs1;
    assign src[1] = id_rs2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // x0 is hardwired to zero and never matches.
            m_match[i]   = m_valid && m_write_gpr && (m_rd == src[i]) && (src[i] != '0);
            w_match[i]   = wb_valid && wb_write_gpr && (wb_rd == src[i]) && (src[i] != '0);
            src_stall[i] = m_match[i] && m_mem_read; // Load data is not ready yet.
            hit[i]       = 1'b0;
            data[i]      = '0;
            if (src_stall[i]) begin
                hit[i] = 1'b0;
            end else if (m_match[i]) begin
                hit[i]  = 1'b1;
                data[i] = m_alu_out;
            end else if (w_match[i]) begin
                hit[i]  = 1'b1;
                data[i] = wb_data;
            end
        end
    end

    assign fwd_rs1_hit    = hit[0];
    assign fwd_rs1_data   = data[0];
    assign fwd_rs2_hit    = hit[1];
    assign fwd_rs2_data   = data[1];
    assign load_use_stall = |src_stall;

endmodule

/* rtl/load_align.sv */
// Load alignment and write-back register.
// Picks the addressed byte or half out of the memory word in m, sign- or
// zero-extends it, and loads the result (or the ALU result for non-loads)
// into stage register w, which drives the write-back handshake.

`include "mem_params.svh"

module load_align import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 m_valid,
    input  mem_word_t            m_rdata,
    input  logic [`XLEN-1:0]     m_pc,
    input  logic [`XLEN-1:0]     m_alu_out,
    input  logic [`REG_BITS-1:0] m_rd,
    input  logic                 m_write_gpr,
    input  logic                 m_mem_read,
    input  logic [1:0]           m_mem_size,
    input  logic                 m_mem_unsigned,

    output logic                 advance_out,

    output logic                 wb_valid,
    input  logic                 wb_ready,
    output logic [`XLEN-1:0]     wb_pc,
    output logic [`REG_BITS-1:0] wb_rd,
    output logic                 wb_write_gpr,
    output logic [`XLEN-1:0]     wb_data
);

    logic [7:0]       load_byte;
    logic [15:0]      load_half;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] result;

    assign advance_out = !wb_valid || wb_ready; // w is empty or being taken.

    // The ALU result still carries the effective address.
    assign load_byte = m_rdata.b[m_alu_out[1:0]];
    assign load_half = m_rdata.h[m_alu_out[1]];

    always_comb begin
        case (m_mem_size)
            `MEM_SZ_BYTE: begin
                load_data = {{(`XLEN-8){load_byte[7] && !m_mem_unsigned}}, load_byte};
            end
            `MEM_SZ_HALF: begin
                load_data = {{(`XLEN-16){load_half[15] && !m_mem_unsigned}}, load_half};
            end
            default: begin
                load_data = m_rdata;
            end
        endcase
    end

    assign result = m_mem_read ? load_data : m_alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else if (advance_out) begin
            wb_valid <= m_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_out && m_valid) begin
            wb_pc        <= m_pc;
            wb_rd        <= m_rd;
            wb_write_gpr <= m_write_gpr;
            wb_data      <= result;
        end
    end

endmodule

/* rtl/data_mem.sv */
// Data memory and stage register m.
// A 256-word byte-enabled synchronous memory. Stores write and loads read on
// the edge that accepts the instruction, and register m captures the read
// word together with the control fields on that same edge.

`include "mem_params.svh"

module data_mem import mem_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`MEM_WORDS_BITS-1:0] word_index,
    input  logic [3:0]                 byte_en,
    input  mem_word_t                  lane_data,
    input  logic                       is_write,
    input  logic                       is_read,
    input  logic [`XLEN-1:0]           pc,
    input  logic [`XLEN-1:0]           alu_out,
    input  logic [`REG_BITS-1:0]       rd,
    input  logic                       write_gpr,
    input  logic [1:0]                 mem_size,
    input  logic                       mem_unsigned,

    input  logic                       advance_out,

    output logic                       m_valid,
    output mem_word_t                  m_rdata,
    output logic [`XLEN-1:0]           m_pc,
    output logic [`XLEN-1:0]           m_alu_out,
    output logic [`REG_BITS-1:0]       m_rd,
    output logic                       m_write_gpr,
    output logic                       m_mem_read,
    output logic [1:0]                 m_mem_size,
    output logic                       m_mem_unsigned
);

    mem_word_t mem_q [`MEM_WORDS];
    logic      accept;

    assign in_ready = !m_valid || advance_out; // Room when m is empty or draining.
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (accept && is_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem_q[word_index].b[i] <= lane_data.b[i];
                end
            end
        end
        if (accept && is_read) begin
            m_rdata <= mem_q[word_index]; // Read data lands in m directly.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else if (accept) begin
            m_valid <= 1'b1;
        end else if (advance_out) begin
            m_valid <= 1'b0; // The entry moved on to w.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m_pc           <= pc;
            m_alu_out      <= alu_out;
            m_rd           <= rd;
            m_write_gpr    <= write_gpr;
            m_mem_read     <= is_read;
            m_mem_size     <= mem_size;
            m_mem_unsigned <= mem_unsigned;
        end
    end

endmodule

/* rtl/mem_req_decode.sv */
// Memory request decode.
// Turns the effective address, access size and store data of one
// instruction into a word index, byte enables and store data that is
// replicated into the addressed lanes.

`include "mem_params.svh"

module mem_req_decode import mem_pkg::*; (
    input  logic [`XLEN-1:0]           addr,
    input  logic [1:0]                 mem_size,
    input  logic [`XLEN-1:0]           store_data,
    output logic [`MEM_WORDS_BITS-1:0] word_index,
    output logic [3:0]                 byte_en,
    output mem_word_t                  lane_data
);

    assign word_index = addr[`MEM_WORDS_BITS+1:2]; // Offset bits are dropped.

    always_comb begin
        case (mem_size)
            `MEM_SZ_BYTE: begin
                byte_en     = 4'b0001 << addr[1:0];
                lane_data.b = {4{store_data[7:0]}}; // Same byte in every lane.
            end
            `MEM_SZ_HALF: begin
                byte_en     = addr[1] ? 4'b1100 : 4'b0011; // Bit 0 is ignored.
                lane_data.h = {2{store_data[15:0]}};
            end
            `MEM_SZ_WORD: begin
                byte_en   = 4'b1111;
                lane_data = store_data;
            end
            default: begin
                // Reserved size code, nothing gets written.
                byte_en   = 4'b0000;
                lane_data = store_data;
            end
        endcase
    end

endmodule

/* rtl/mem_pkg.sv */
// Memory stage types.
// A data memory word seen either as four byte lanes or as two half lanes.

package mem_pkg;

    typedef union packed {
        logic [3:0][7:0]  b; // Lane 0 is the byte at address offset 0.
        logic [1:0][15:0] h; // Half 0 covers bytes 0 and 1.
    } mem_word_t;

endpackage

/* include/mem_params.svh */
// Memory stage parameters.
// Widths, data memory depth and the access-size codes shared by the memory
// stage of the RV32 pipeline and its testbench.

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`define XLEN            32
`define REG_BITS        5

// Word index width; the data memory holds 2**MEM_WORDS_BITS words.
`define MEM_WORDS_BITS  8
`define MEM_WORDS       (1 << `MEM_WORDS_BITS)

`define MEM_SZ_BYTE     2'd0 // LB, LBU, SB.
`define MEM_SZ_HALF     2'd1 // LH, LHU, SH.
`define MEM_SZ_WORD     2'd2 // LW, SW.

`endif
